/* project.f */
rtl/ebox_pkg.sv
rtl/fetch_pc.sv
rtl/branch_cond.sv
rtl/inst_pipe.sv
rtl/bypass_select.sv
rtl/ibox_decode.sv
rtl/ebox_top.sv
testbench/tb_ebox.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the ebox testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
  -f project.f --top-module tb_ebox \
  --Mdir obj_dir -o tb_ebox
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

output=$(./obj_dir/tb_ebox 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "RESULT: PASS"; then
  exit 0
fi
exit 1

/* testbench/tb_ebox.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ebox;

  localparam ebox_pkg::addr_t  RESET_PC = 64'h0000_0000_0001_0000;
  localparam ebox_pkg::opcode_t OP_BEQ  = 6'h39;
  localparam ebox_pkg::opcode_t OP_LDQ  = 6'h29;
  localparam ebox_pkg::opcode_t OP_STQ  = 6'h2D;
  localparam ebox_pkg::opcode_t OP_SHFT = 6'h12;   // Dropped group, decodes to zero
  localparam logic [20:0]      BR_DISP  = 21'h1F_FFFA;  // Minus six longwords

  logic                 clk;
  logic                 rst_n;
  ebox_pkg::inst_t      inst;
  ebox_pkg::addr_t      reg_a;
  ebox_pkg::addr_t      reg_b;
  ebox_pkg::addr_t      ibox_result;
  logic                 i_stall;
  logic                 d_stall;
  ebox_pkg::addr_t      pc;
  ebox_pkg::ibox_ctrl_t ibox_ctrl;
  ebox_pkg::fwd_sel_t   fwd_a_sel;
  ebox_pkg::fwd_sel_t   fwd_b_sel;
  logic [1:0]           irf_m1_sel;
  logic                 irf_m2_sel;
  logic [7:0]           literal;
  logic [15:0]          displacement;
  ebox_pkg::reg_addr_t  ra_addr;
  ebox_pkg::reg_addr_t  rb_addr;
  logic                 mem_w_en;
  ebox_pkg::wb_ctrl_t   wb_ctrl;

  logic [31:0]          lcg_state;
  ebox_pkg::addr_t      exp_pc;
  ebox_pkg::addr_t      br_addr;
  int                   cycles;

  ebox_top #(.RESET_PC(RESET_PC), .LITTLE_ENDIAN(1'b0)) dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .inst        (inst),
    .reg_a       (reg_a),
    .reg_b       (reg_b),
    .ibox_result (ibox_result),
    .i_stall     (i_stall),
    .d_stall     (d_stall),
    .pc          (pc),
    .ibox_ctrl   (ibox_ctrl),
    .fwd_a_sel   (fwd_a_sel),
    .fwd_b_sel   (fwd_b_sel),
    .irf_m1_sel  (irf_m1_sel),
    .irf_m2_sel  (irf_m2_sel),
    .literal     (literal),
    .displacement(displacement),
    .ra_addr     (ra_addr),
    .rb_addr     (rb_addr),
    .mem_w_en    (mem_w_en),
    .wb_ctrl     (wb_ctrl)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic ebox_pkg::addr_t random_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_random();
    lo = next_random();
    return {hi, lo};
  endfunction

  function automatic ebox_pkg::inst_t operate_word(input ebox_pkg::opcode_t op,
                                                   input ebox_pkg::reg_addr_t ra,
                                                   input ebox_pkg::reg_addr_t rb,
                                                   input ebox_pkg::func_t fn,
                                                   input ebox_pkg::reg_addr_t rc);
    return {op, ra, rb, 3'b000, 1'b0, fn, rc};     // Register form, no literal
  endfunction

  function automatic ebox_pkg::inst_t memory_word(input ebox_pkg::opcode_t op,
                                                  input ebox_pkg::reg_addr_t ra,
                                                  input ebox_pkg::reg_addr_t rb,
                                                  input logic [15:0] disp);
    return {op, ra, rb, disp};
  endfunction

  function automatic ebox_pkg::inst_t branch_word(input ebox_pkg::opcode_t op,
                                                  input ebox_pkg::reg_addr_t ra,
                                                  input logic [20:0] disp);
    return {op, ra, disp};
  endfunction

  // Branch address + 4 + 4 * sign-extended displacement
  function automatic ebox_pkg::addr_t branch_dest(input ebox_pkg::addr_t addr,
                                                  input logic [20:0] disp);
    ebox_pkg::addr_t offs;
    offs = {{43{disp[20]}}, disp};
    return addr + 64'd4 + (offs << 2);
  endfunction

  task automatic report_error(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out at %0t ns while waiting for %s", $time, what);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on timeout");
  endtask

  // Drive on the falling edge, return at the next falling edge
  task automatic advance_cycle(input ebox_pkg::inst_t next_inst);
    inst = next_inst;
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic expect_pc(input ebox_pkg::addr_t exp, input string what);
    assert (pc == exp) else report_error($sformatf("%s: pc %h, expected %h", what, pc, exp));
  endtask

  task automatic check_stage2_fields(input ebox_pkg::reg_addr_t ra,
                                     input ebox_pkg::reg_addr_t rb,
                                     input logic [15:0] disp, input logic [7:0] lit,
                                     input logic [1:0] m1, input logic m2,
                                     input string name);
    assert (ra_addr == ra && rb_addr == rb)
      else report_error($sformatf("%s: ra %0d rb %0d, expected ra %0d rb %0d",
                                  name, ra_addr, rb_addr, ra, rb));
    assert (displacement == disp && literal == lit)
      else report_error($sformatf("%s: displacement %h literal %h, expected %h %h",
                                  name, displacement, literal, disp, lit));
    assert (irf_m1_sel == m1 && irf_m2_sel == m2)
      else report_error($sformatf("%s: irf_m1_sel %b irf_m2_sel %b, expected %b %b",
                                  name, irf_m1_sel, irf_m2_sel, m1, m2));
  endtask

  task automatic check_writeback(input logic [1:0] m1, input logic m2, input logic m3,
                                 input ebox_pkg::reg_addr_t ra,
                                 input ebox_pkg::reg_addr_t rc, input string name);
    assert (wb_ctrl.reg_w == 1'b1) else report_error($sformatf("%s: reg_w clear", name));
    assert (wb_ctrl.m1_sel == m1 && wb_ctrl.m2_sel == m2 && wb_ctrl.m3_sel == m3)
      else report_error($sformatf("%s: m1 %b m2 %b m3 %b, expected %b %b %b", name,
                                  wb_ctrl.m1_sel, wb_ctrl.m2_sel, wb_ctrl.m3_sel,
                                  m1, m2, m3));
    assert (wb_ctrl.ra_addr == ra && wb_ctrl.rc_addr == rc)
      else report_error($sformatf("%s: ra %0d rc %0d, expected ra %0d rc %0d", name,
                                  wb_ctrl.ra_addr, wb_ctrl.rc_addr, ra, rc));
  endtask

  task automatic drain_pipeline();
    repeat (4) begin
      advance_cycle(ebox_pkg::NOP_INST);
      exp_pc = exp_pc + 64'd4;
      expect_pc(exp_pc, "drain");
    end
  endtask

  task automatic check_decode(input ebox_pkg::inst_t word, input logic [4:0] alu,
                              input logic [2:0] mux2, input string name);
    advance_cycle(word);
    advance_cycle(ebox_pkg::NOP_INST);         // Now in stage 3
    exp_pc = exp_pc + 64'd8;
    expect_pc(exp_pc, name);
    assert (ibox_ctrl.alu == alu && ibox_ctrl.mux2 == mux2)
      else report_error($sformatf("%s: alu %0d mux2 %0d, expected alu %0d mux2 %0d",
                                  name, ibox_ctrl.alu, ibox_ctrl.mux2, alu, mux2));
  endtask

  task automatic wait_for_writeback(input int limit, output int n);
    n = 1;                                     // Fetch edge already taken
    while (!wb_ctrl.reg_w) begin
      if (n >= limit) begin
        report_timeout("writeback reg_w");
      end
      advance_cycle(ebox_pkg::NOP_INST);
      n = n + 1;
    end
  endtask

  initial begin
    lcg_state   = 32'h6d99;
    rst_n       = 1'b0;
    inst        = ebox_pkg::NOP_INST;
    reg_a       = '0;
    reg_b       = '0;
    ibox_result = '0;
    i_stall     = 1'b0;
    d_stall     = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    expect_pc(RESET_PC, "after reset");
    assert (wb_ctrl.reg_w == 1'b0 && mem_w_en == 1'b0)
      else report_error("reg_w or mem_w_en set after reset");
    assert (fwd_a_sel == ebox_pkg::FWD_NONE && fwd_b_sel == ebox_pkg::FWD_NONE)
      else report_error("bypass selects nonzero after reset");
    exp_pc = RESET_PC;
    repeat (4) begin
      advance_cycle(ebox_pkg::NOP_INST);
      exp_pc = exp_pc + 64'd4;
      expect_pc(exp_pc, "sequential fetch");
    end
    d_stall = 1'b1;
    repeat (3) begin
      advance_cycle(ebox_pkg::NOP_INST);
      expect_pc(exp_pc, "d_stall freeze");
    end
    d_stall = 1'b0;
    advance_cycle(ebox_pkg::NOP_INST);
    exp_pc = exp_pc + 64'd4;
    expect_pc(exp_pc, "after d_stall");

    // Taken BEQ with a zero operand
    br_addr = exp_pc;
    reg_a   = '0;
    advance_cycle(branch_word(OP_BEQ, 5'd3, BR_DISP));
    expect_pc(br_addr + 64'd4, "BEQ in stage 2");
    advance_cycle(ebox_pkg::NOP_INST);
    exp_pc = branch_dest(br_addr, BR_DISP);
    expect_pc(exp_pc, "taken BEQ");
    advance_cycle(ebox_pkg::NOP_INST);
    exp_pc = exp_pc + 64'd4;
    expect_pc(exp_pc, "after taken BEQ");

    // Same BEQ, nonzero operand
    br_addr = exp_pc;
    reg_a   = random_word();
    if (reg_a == '0) begin
      reg_a = 64'd1;
    end
    advance_cycle(branch_word(OP_BEQ, 5'd3, BR_DISP));
    exp_pc = br_addr + 64'd4;
    expect_pc(exp_pc, "BEQ in stage 2");
    advance_cycle(ebox_pkg::NOP_INST);
    expect_pc(exp_pc, "not-taken BEQ hold");
    advance_cycle(ebox_pkg::NOP_INST);
    exp_pc = exp_pc + 64'd4;
    expect_pc(exp_pc, "after not-taken BEQ");
    reg_a = '0;

    reg_b = random_word();
    advance_cycle(memory_word(ebox_pkg::OP_JMP, 5'd26, 5'd27, 16'h0000));
    exp_pc = exp_pc + 64'd4;
    expect_pc(exp_pc, "JMP in stage 2");
    check_stage2_fields(5'd26, 5'd27, 16'h0000, 8'hD8, 2'b10, 1'b0, "JMP in stage 2");
    advance_cycle(ebox_pkg::NOP_INST);
    exp_pc = reg_b & ~64'd3;
    expect_pc(exp_pc, "JMP target");
    advance_cycle(ebox_pkg::NOP_INST);
    exp_pc = exp_pc + 64'd4;
    expect_pc(exp_pc, "after JMP");

    check_decode(operate_word(ebox_pkg::OP_INTA, 5'd1, 5'd2, 7'h20, 5'd3), 5'd1, 3'd0, "ADDQ");
    check_decode(operate_word(ebox_pkg::OP_INTA, 5'd1, 5'd2, 7'h29, 5'd3), 5'd2, 3'd0, "SUBQ");
    check_decode(operate_word(ebox_pkg::OP_INTL, 5'd1, 5'd2, 7'h00, 5'd3), 5'd3, 3'd0, "AND");
    check_decode(operate_word(ebox_pkg::OP_INTL, 5'd1, 5'd2, 7'h40, 5'd3), 5'd5, 3'd0, "XOR");
    check_decode(memory_word(OP_LDQ, 5'd1, 5'd2, 16'h0010), 5'd1, 3'd5, "LDQ");
    check_decode(operate_word(OP_SHFT, 5'd1, 5'd2, 7'h39, 5'd3), 5'd0, 3'd0, "SLL");
    assert (ibox_ctrl == '0) else report_error("opcode 0x12 gives nonzero ibox_ctrl");

    advance_cycle(operate_word(ebox_pkg::OP_INTA, 5'd1, 5'd2, 7'h20, 5'd5));
    advance_cycle(operate_word(ebox_pkg::OP_INTA, 5'd5, 5'd6, 7'h20, 5'd8));
    exp_pc = exp_pc + 64'd8;
    expect_pc(exp_pc, "ALU producer and reader");
    check_stage2_fields(5'd5, 5'd6, 16'h0408, 8'h30, 2'b00, 1'b0, "ADDQ reader");
    assert (fwd_a_sel == ebox_pkg::FWD_EX && fwd_b_sel == ebox_pkg::FWD_NONE)
      else report_error($sformatf("ALU bypass: a %0d b %0d", fwd_a_sel, fwd_b_sel));
    drain_pipeline();

    advance_cycle(memory_word(OP_LDQ, 5'd7, 5'd2, 16'h0000));
    check_stage2_fields(5'd7, 5'd2, 16'h0000, 8'h10, 2'b01, 1'b0, "LDQ in stage 2");
    advance_cycle(operate_word(ebox_pkg::OP_INTA, 5'd7, 5'd9, 7'h20, 5'd10));
    exp_pc = exp_pc + 64'd8;
    expect_pc(exp_pc, "load and reader");
    advance_cycle(ebox_pkg::NOP_INST);
    expect_pc(exp_pc, "load-use interlock");
    assert (fwd_a_sel == ebox_pkg::FWD_LOAD)
      else report_error($sformatf("load bypass: a %0d, expected %0d", fwd_a_sel,
                                  ebox_pkg::FWD_LOAD));
    advance_cycle(ebox_pkg::NOP_INST);
    exp_pc = exp_pc + 64'd4;
    expect_pc(exp_pc, "after interlock");
    check_writeback(2'b01, 1'b1, 1'b0, 5'd7, 5'd0, "LDQ writeback");
    drain_pipeline();

    assert (wb_ctrl.reg_w == 1'b0) else report_error("reg_w set with empty pipeline");
    advance_cycle({ebox_pkg::OP_INTL, 5'd3, 8'hA5, 1'b1, 7'h00, 5'd12});  // AND, literal form
    check_stage2_fields(5'd3, 5'd20, 16'hB00C, 8'hA5, 2'b00, 1'b1, "AND literal");
    wait_for_writeback(10, cycles);
    assert (cycles == 4) else report_error($sformatf("writeback after %0d cycles", cycles));
    check_writeback(2'b00, 1'b0, 1'b0, 5'd3, 5'd12, "AND writeback");

    advance_cycle(memory_word(OP_STQ, 5'd4, 5'd2, 16'h0008));
    advance_cycle(ebox_pkg::NOP_INST);         // Store in stage 3
    assert (mem_w_en == 1'b0) else report_error("mem_w_en set before store left stage 3");
    advance_cycle(ebox_pkg::NOP_INST);
    assert (mem_w_en == 1'b1) else report_error("mem_w_en clear after store in stage 3");
    advance_cycle(ebox_pkg::NOP_INST);
    assert (mem_w_en == 1'b0) else report_error("mem_w_en still set after store");

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/ebox_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ebox_top #(
  parameter ebox_pkg::addr_t RESET_PC      = 64'h0,
  parameter bit              LITTLE_ENDIAN = 1'b1
) (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire ebox_pkg::inst_t inst,
  input  wire ebox_pkg::addr_t reg_a,
  input  wire ebox_pkg::addr_t reg_b,
  input  wire ebox_pkg::addr_t ibox_result,
  input  wire logic            i_stall,
  input  wire logic            d_stall,
  output ebox_pkg::addr_t      pc,
  output ebox_pkg::ibox_ctrl_t ibox_ctrl,
  output ebox_pkg::fwd_sel_t   fwd_a_sel,
  output ebox_pkg::fwd_sel_t   fwd_b_sel,
  output logic [1:0]           irf_m1_sel,
  output logic                 irf_m2_sel,
  output logic [7:0]           literal,
  output logic [15:0]          displacement,
  output ebox_pkg::reg_addr_t  ra_addr,
  output ebox_pkg::reg_addr_t  rb_addr,
  output logic                 mem_w_en,
  output ebox_pkg::wb_ctrl_t   wb_ctrl
);

  ebox_pkg::inst_t        inst2, inst3, inst4, inst5;
  ebox_pkg::stage_flags_t flags3, flags4, flags5;
  ebox_pkg::inst_fields_t f2;
  ebox_pkg::inst_fields_t f5;
  ebox_pkg::addr_t        br_target;
  logic is_branch;
  logic take_branch;
  logic jump2;
  logic ld_dep;
  logic bubble;
  logic res0_q;                               // CMOV condition seen one cycle ago
  logic mem_fmt2;
  logic mem_fmt5;

  assign bubble = is_branch | i_stall;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res0_q <= 1'b0;
    end else begin
      res0_q <= ibox_result[0];
    end
  end

  // Redirects wait while the interlock holds stage 2
  fetch_pc #(.RESET_PC(RESET_PC)) u_fetch_pc (
    .clk        (clk),
    .rst_n      (rst_n),
    .bubble     (bubble),
    .hold       (ld_dep | d_stall),
    .jump       (jump2 & ~ld_dep),
    .take_branch(take_branch & ~ld_dep),
    .br_target  (br_target),
    .jmp_target (reg_b),
    .pc         (pc)
  );

  branch_cond u_branch_cond (
    .inst2      (inst2),
    .reg_a      (reg_a),
    .pc         (pc),
    .is_branch  (is_branch),
    .take_branch(take_branch),
    .br_target  (br_target)
  );

  inst_pipe u_inst_pipe (
    .clk     (clk),
    .rst_n   (rst_n),
    .inst    (inst),
    .d_stall (d_stall),
    .squash2 (bubble),
    .inst2   (inst2),
    .inst3   (inst3),
    .inst4   (inst4),
    .inst5   (inst5),
    .flags3  (flags3),
    .flags4  (flags4),
    .flags5  (flags5),
    .jump2   (jump2),
    .ld_dep  (ld_dep),
    .mem_w_en(mem_w_en)
  );

  bypass_select u_bypass_select (
    .inst2    (inst2),
    .inst3    (inst3),
    .inst4    (inst4),
    .flags3   (flags3),
    .flags4   (flags4),
    .cmov_ok3 (ibox_result[0]),
    .cmov_ok4 (res0_q),
    .fwd_a_sel(fwd_a_sel),
    .fwd_b_sel(fwd_b_sel)
  );

  ibox_decode #(.LITTLE_ENDIAN(LITTLE_ENDIAN)) u_ibox_decode (
    .inst3    (inst3),
    .ibox_ctrl(ibox_ctrl)
  );

  assign f2 = inst2;
  assign f5 = inst5;

  // Memory format has opcode bit 4 clear; opcode 0 is the NOP
  assign mem_fmt2 = ~f2.opcode[4] & (|f2.opcode);
  assign mem_fmt5 = ~f5.opcode[4] & (|f5.opcode);

  assign literal      = inst2[20:13];
  assign displacement = f2.low;
  assign ra_addr      = f2.ra;
  assign rb_addr      = f2.rb;
  assign irf_m1_sel   = {jump2, mem_fmt2};
  assign irf_m2_sel   = inst2[12] & ebox_pkg::is_operate(f2.opcode);   // Literal operand

  always_comb begin
    wb_ctrl.reg_w   = flags5.reg_w;
    wb_ctrl.m1_sel  = {flags5.cmov, mem_fmt5};
    wb_ctrl.m2_sel  = mem_fmt5 | flags5.jump;
    wb_ctrl.m3_sel  = flags5.cmov;
    wb_ctrl.ra_addr = f5.ra;
    wb_ctrl.rc_addr = ebox_pkg::rc_of(f5);
  end

endmodule

`default_nettype wire

/* rtl/ibox_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module ibox_decode #(
  parameter bit LITTLE_ENDIAN = 1'b1
) (
  input  wire ebox_pkg::inst_t inst3,
  output ebox_pkg::ibox_ctrl_t ibox_ctrl
);

  localparam logic [2:0] SWAP = LITTLE_ENDIAN ? 3'h0 : 3'h5;  // Byte swap on big-endian

  ebox_pkg::inst_fields_t f3;
  ebox_pkg::func_t        fn;

  assign f3 = inst3;
  assign fn = ebox_pkg::func_of(f3);

  // Kept rows never use shifter, mei, mux0 or mux3
  function automatic ebox_pkg::ibox_ctrl_t row(input logic [5:0] n_shift,
                                               input logic [4:0] alu,
                                               input logic [2:0] cmp,
                                               input logic [2:0] xor_sel,
                                               input logic       mux1,
                                               input logic [2:0] mux2,
                                               input logic       v);
    ebox_pkg::ibox_ctrl_t c;
    c         = '0;
    c.n_shift = n_shift;
    c.alu     = alu;
    c.cmp     = cmp;
    c.xor_sel = xor_sel;
    c.mux1    = mux1;
    c.mux2    = mux2;
    c.v       = v;
    return c;
  endfunction

  always_comb begin
    ibox_ctrl = '0;
    case (f3.opcode)
      6'h08: ibox_ctrl = row(6'h00, 5'h1, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0);          // LDA
      6'h09: ibox_ctrl = row(6'h10, 5'h1, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0);          // LDAH
      6'h0A, 6'h0E: ibox_ctrl = row(6'h00, 5'h1, 3'h0, 3'h7, 1'b0, SWAP, 1'b0);   // Byte
      6'h0B, 6'h0F: ibox_ctrl = row(6'h00, 5'h1, 3'h0, 3'h0, 1'b0, 3'h3, 1'b0);   // Unaligned
      6'h0C, 6'h0D: ibox_ctrl = row(6'h00, 5'h1, 3'h0, 3'h6, 1'b0, SWAP, 1'b0);   // Word
      6'h28, 6'h2A, 6'h2C, 6'h2E: begin
        ibox_ctrl = row(6'h00, 5'h1, 3'h0, 3'h4, 1'b0, SWAP, 1'b0);               // Longword
      end
      6'h29, 6'h2B, 6'h2D, 6'h2F: begin
        ibox_ctrl = row(6'h00, 5'h1, 3'h0, 3'h0, 1'b0, SWAP, 1'b0);               // Quadword
      end
      ebox_pkg::OP_INTA: begin
        case (fn)
          7'h00: ibox_ctrl = row(6'h00, 5'h1, 3'h0, 3'h0, 1'b0, 3'h1, 1'b0);      // ADDL
          7'h02: ibox_ctrl = row(6'h02, 5'h1, 3'h0, 3'h0, 1'b0, 3'h1, 1'b0);      // S4ADDL
          7'h09: ibox_ctrl = row(6'h00, 5'h2, 3'h0, 3'h0, 1'b0, 3'h1, 1'b0);      // SUBL
          7'h0B: ibox_ctrl = row(6'h02, 5'h2, 3'h0, 3'h0, 1'b0, 3'h1, 1'b0);      // S4SUBL
          7'h0F: ibox_ctrl = row(6'h00, 5'h6, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0);      // CMPBGE
          7'h12: ibox_ctrl = row(6'h03, 5'h1, 3'h0, 3'h0, 1'b0, 3'h1, 1'b0);      // S8ADDL
          7'h1B: ibox_ctrl = row(6'h03, 5'h2, 3'h0, 3'h0, 1'b0, 3'h1, 1'b0);      // S8SUBL
          7'h1D: ibox_ctrl = row(6'h00, 5'h2, 3'h5, 3'h0, 1'b0, 3'h2, 1'b0);      // CMPULT
          7'h20: ibox_ctrl = row(6'h00, 5'h1, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0);      // ADDQ
          7'h22: ibox_ctrl = row(6'h02, 5'h1, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0);      // S4ADDQ
          7'h29: ibox_ctrl = row(6'h00, 5'h2, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0);      // SUBQ
          7'h2B: ibox_ctrl = row(6'h02, 5'h2, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0);      // S4SUBQ
          7'h2D: ibox_ctrl = row(6'h00, 5'h2, 3'h2, 3'h0, 1'b0, 3'h2, 1'b0);      // CMPEQ
          7'h32: ibox_ctrl = row(6'h03, 5'h1, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0);      // S8ADDQ
          7'h3B: ibox_ctrl = row(6'h03, 5'h2, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0);      // S8SUBQ
          7'h3D: ibox_ctrl = row(6'h00, 5'h2, 3'h6, 3'h0, 1'b0, 3'h2, 1'b0);      // CMPULE
          7'h40: ibox_ctrl = row(6'h00, 5'h1, 3'h0, 3'h0, 1'b0, 3'h1, 1'b1);      // ADDL/V
          7'h49: ibox_ctrl = row(6'h00, 5'h2, 3'h0, 3'h0, 1'b0, 3'h1, 1'b1);      // SUBL/V
          7'h4D: ibox_ctrl = row(6'h00, 5'h2, 3'h0, 3'h0, 1'b0, 3'h2, 1'b0);      // CMPLT
          7'h60: ibox_ctrl = row(6'h00, 5'h1, 3'h0, 3'h0, 1'b0, 3'h0, 1'b1);      // ADDQ/V
          7'h69: ibox_ctrl = row(6'h00, 5'h2, 3'h0, 3'h0, 1'b0, 3'h0, 1'b1);      // SUBQ/V
          7'h6D: ibox_ctrl = row(6'h00, 5'h2, 3'h3, 3'h0, 1'b0, 3'h2, 1'b0);      // CMPLE
          default: ibox_ctrl = '0;
        endcase
      end
      ebox_pkg::OP_INTL: begin
        case (fn)
          7'h00: ibox_ctrl = row(6'h00, 5'h3, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0);      // AND
          7'h08: ibox_ctrl = row(6'h00, 5'h3, 3'h0, 3'h0, 1'b1, 3'h0, 1'b0);      // BIC
          7'h14: ibox_ctrl = row(6'h3F, 5'h0, 3'h0, 3'h0, 1'b0, 3'h2, 1'b0);      // CMOVLBS
          7'h16: ibox_ctrl = row(6'h3F, 5'h0, 3'h2, 3'h0, 1'b0, 3'h2, 1'b0);      // CMOVLBC
          7'h20: ibox_ctrl = row(6'h00, 5'h4, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0);      // BIS
          7'h24: ibox_ctrl = row(6'h00, 5'h0, 3'h3, 3'h0, 1'b0, 3'h2, 1'b0);      // CMOVEQ
          7'h26: ibox_ctrl = row(6'h00, 5'h0, 3'h7, 3'h0, 1'b0, 3'h2, 1'b0);      // CMOVNE
          7'h28: ibox_ctrl = row(6'h00, 5'h4, 3'h0, 3'h0, 1'b1, 3'h0, 1'b0);      // ORNOT
          7'h40: ibox_ctrl = row(6'h00, 5'h5, 3'h0, 3'h0, 1'b0, 3'h0, 1'b0);      // XOR
          7'h44: ibox_ctrl = row(6'h00, 5'h0, 3'h0, 3'h0, 1'b0, 3'h2, 1'b0);      // CMOVLT
          7'h46: ibox_ctrl = row(6'h00, 5'h0, 3'h4, 3'h0, 1'b0, 3'h2, 1'b0);      // CMOVGE
          7'h48: ibox_ctrl = row(6'h00, 5'h5, 3'h0, 3'h0, 1'b1, 3'h0, 1'b0);      // EQV
          7'h64: ibox_ctrl = row(6'h00, 5'h0, 3'h3, 3'h0, 1'b0, 3'h2, 1'b0);      // CMOVLE
          7'h66: ibox_ctrl = row(6'h00, 5'h0, 3'h1, 3'h0, 1'b0, 3'h2, 1'b0);      // CMOVGT
          default: ibox_ctrl = '0;
        endcase
      end
      default: ibox_ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/bypass_select.sv */
`timescale 1ns/1ps
`default_nettype none

module bypass_select (
  input  wire ebox_pkg::inst_t        inst2,
  input  wire ebox_pkg::inst_t        inst3,
  input  wire ebox_pkg::inst_t        inst4,
  input  wire ebox_pkg::stage_flags_t flags3,
  input  wire ebox_pkg::stage_flags_t flags4,
  input  wire logic                   cmov_ok3,   // CMOV condition met in stage 3
  input  wire logic                   cmov_ok4,
  output ebox_pkg::fwd_sel_t          fwd_a_sel,
  output ebox_pkg::fwd_sel_t          fwd_b_sel
);

  ebox_pkg::inst_fields_t f2;
  ebox_pkg::inst_fields_t f3;
  ebox_pkg::inst_fields_t f4;
  ebox_pkg::reg_addr_t    rc3;
  ebox_pkg::reg_addr_t    rc4;
  ebox_pkg::reg_addr_t    dest3;
  ebox_pkg::reg_addr_t    dest4;
  logic alu3;
  logic alu4;

  assign f2 = inst2;
  assign f3 = inst3;
  assign f4 = inst4;

  assign rc3 = ebox_pkg::rc_of(f3);
  assign rc4 = ebox_pkg::rc_of(f4);

  // Jumps write the return address to ra, operates write rc
  assign dest3 = (flags3.jump | flags3.load) ? f3.ra : rc3;
  assign dest4 = (flags4.jump | flags4.load) ? f4.ra : rc4;

  // Unconditional ALU results only
  assign alu3 = flags3.reg_w & ~flags3.load & ~flags3.cmov;
  assign alu4 = flags4.reg_w & ~flags4.load & ~flags4.cmov;

  function automatic ebox_pkg::fwd_sel_t pick(ebox_pkg::reg_addr_t src);
    if (alu3 && src == dest3) begin
      return ebox_pkg::FWD_EX;
    end else if (alu4 && src == dest4) begin
      return ebox_pkg::FWD_MEM;
    end else if (flags4.load && src == f4.ra) begin
      return ebox_pkg::FWD_LOAD;
    end else if (flags3.cmov && cmov_ok3 && src == rc3) begin
      return ebox_pkg::FWD_CMOV_EX;
    end else if (flags4.cmov && cmov_ok4 && src == rc4) begin
      return ebox_pkg::FWD_CMOV_MEM;
    end
    return ebox_pkg::FWD_NONE;
  endfunction

  always_comb begin
    fwd_a_sel = pick(f2.ra);
    fwd_b_sel = pick(f2.rb);
  end

endmodule

`default_nettype wire

/* rtl/inst_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_pipe (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire ebox_pkg::inst_t   inst,
  input  wire logic              d_stall,
  input  wire logic              squash2,    // Kill the slot entering stage 2
  output ebox_pkg::inst_t        inst2,
  output ebox_pkg::inst_t        inst3,
  output ebox_pkg::inst_t        inst4,
  output ebox_pkg::inst_t        inst5,
  output ebox_pkg::stage_flags_t flags3,
  output ebox_pkg::stage_flags_t flags4,
  output ebox_pkg::stage_flags_t flags5,
  output logic                   jump2,
  output logic                   ld_dep,
  output logic                   mem_w_en
);

  ebox_pkg::inst_fields_t f2;
  ebox_pkg::inst_fields_t f3;
  ebox_pkg::inst_fields_t f4;
  ebox_pkg::stage_flags_t flags2;
  logic kill2;
  logic store3;
  logic stc4;

  assign f2 = inst2;
  assign f3 = inst3;
  assign f4 = inst4;

  assign jump2 = (f2.opcode == ebox_pkg::OP_JMP);

  always_comb begin
    flags2.load  = ebox_pkg::is_load(f2.opcode);
    flags2.jump  = jump2;
    flags2.cmov  = ebox_pkg::is_cmov(f2);
    flags2.reg_w = ebox_pkg::is_operate(f2.opcode) | flags2.load | jump2;
  end

  // A redirect in stage 2 discards the instruction fetched behind it
  assign kill2  = squash2 | jump2;
  assign ld_dep = flags3.load && (f2.ra == f3.ra || f2.rb == f3.ra);

  // Memory format with bit 30 low, excluding loads and CALL_PAL
  assign store3 = ~f3.opcode[4] & ~flags3.load & (|f3.opcode);
  assign stc4   = (f4.opcode == ebox_pkg::OP_STL_C) || (f4.opcode == ebox_pkg::OP_STQ_C);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inst2    <= ebox_pkg::NOP_INST;
      inst3    <= ebox_pkg::NOP_INST;
      inst4    <= ebox_pkg::NOP_INST;
      inst5    <= ebox_pkg::NOP_INST;
      flags3   <= '0;
      flags4   <= '0;
      flags5   <= '0;
      mem_w_en <= 1'b0;
    end else begin
      if (ld_dep) begin
        inst2 <= inst2;                       // Hold the consumer
      end else if (kill2) begin
        inst2 <= ebox_pkg::NOP_INST;
      end else if (!d_stall) begin
        inst2 <= inst;
      end

      if (!d_stall) begin
        if (ld_dep) begin
          inst3  <= ebox_pkg::NOP_INST;      // Interlock bubble
          flags3 <= '0;
        end else begin
          inst3  <= inst2;
          flags3 <= flags2;
        end
        inst4  <= inst3;
        flags4 <= flags3;
      end

      if (d_stall) begin
        inst5  <= ebox_pkg::NOP_INST;
        flags5 <= '0;
      end else begin
        inst5  <= inst4;
        flags5 <= flags4;
      end

      mem_w_en <= store3 | stc4;
    end
  end

endmodule

`default_nettype wire

/* rtl/branch_cond.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_cond (
  input  wire ebox_pkg::inst_t inst2,
  input  wire ebox_pkg::addr_t reg_a,
  input  wire ebox_pkg::addr_t pc,           // Already branch address + 4
  output logic                 is_branch,
  output logic                 take_branch,
  output ebox_pkg::addr_t      br_target
);

  logic neg;
  logic zero;
  logic cond;

  assign neg       = reg_a[63];
  assign zero      = (reg_a == '0);
  assign is_branch = (inst2[31:30] == 2'b11);

  always_comb begin
    case (inst2[29:26])
      4'h0, 4'h4: cond = 1'b1;               // BR, BSR
      4'h8:       cond = ~reg_a[0];          // BLBC
      4'h9:       cond = zero;               // BEQ
      4'hA:       cond = neg;                // BLT
      4'hB:       cond = neg | zero;         // BLE
      4'hC:       cond = reg_a[0];           // BLBS
      4'hD:       cond = ~zero;              // BNE
      4'hE:       cond = ~neg;               // BGE
      4'hF:       cond = ~neg & ~zero;       // BGT
      default:    cond = 1'b0;               // FP branches not handled here
    endcase
  end

  assign take_branch = is_branch & cond;
  assign br_target   = pc + {{41{inst2[20]}}, inst2[20:0], 2'b00};

endmodule

`default_nettype wire

/* rtl/fetch_pc.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_pc #(
  parameter ebox_pkg::addr_t RESET_PC = 64'h0
) (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            bubble,       // Branch in stage 2 or fetch stall
  input  wire logic            hold,         // Interlock or data stall
  input  wire logic            jump,
  input  wire logic            take_branch,
  input  wire ebox_pkg::addr_t br_target,
  input  wire ebox_pkg::addr_t jmp_target,
  output ebox_pkg::addr_t      pc
);

  ebox_pkg::addr_t pc_next;
  ebox_pkg::addr_t pc_plus4;

  assign pc_plus4 = pc + 64'd4;

  always_comb begin
    if (jump) begin
      pc_next = {jmp_target[63:2], 2'b00};   // Jumps are longword aligned
    end else if (take_branch) begin
      pc_next = br_target;
    end else if (bubble || hold) begin
      pc_next = pc;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

/* rtl/ebox_pkg.sv */
`default_nettype none

package ebox_pkg;

  typedef logic [63:0] addr_t;      // Program address or data word
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [6:0]  func_t;

  localparam opcode_t OP_INTA  = 6'h10;
  localparam opcode_t OP_INTL  = 6'h11;
  localparam opcode_t OP_JMP   = 6'h1A;
  localparam opcode_t OP_STL_C = 6'h2E;
  localparam opcode_t OP_STQ_C = 6'h2F;

  localparam inst_t NOP_INST = 32'h0000_0000;

  // Operate format packs literal, func and rc into the low half
  localparam int RC_MSB   = 4;
  localparam int RC_LSB   = 0;
  localparam int FUNC_MSB = 11;
  localparam int FUNC_LSB = 5;

  typedef struct packed {
    opcode_t     opcode;
    reg_addr_t   ra;
    reg_addr_t   rb;
    logic [15:0] low;               // Displacement or operate fields
  } inst_fields_t;

  typedef logic [2:0] fwd_sel_t;

  localparam fwd_sel_t FWD_NONE     = 3'd0;
  localparam fwd_sel_t FWD_EX       = 3'd1;
  localparam fwd_sel_t FWD_MEM      = 3'd2;
  localparam fwd_sel_t FWD_LOAD     = 3'd3;
  localparam fwd_sel_t FWD_CMOV_EX  = 3'd5;
  localparam fwd_sel_t FWD_CMOV_MEM = 3'd6;

  typedef struct packed {
    logic reg_w;
    logic load;
    logic jump;
    logic cmov;
  } stage_flags_t;

  typedef struct packed {
    logic [5:0] n_shift;
    logic [1:0] shifter;
    logic [4:0] alu;
    logic [2:0] cmp;
    logic [4:0] mei;
    logic [2:0] xor_sel;
    logic       mux0;
    logic       mux1;
    logic [2:0] mux2;
    logic [1:0] mux3;
    logic       v;                  // Trap on overflow
  } ibox_ctrl_t;

  typedef struct packed {
    logic      reg_w;
    logic [1:0] m1_sel;
    logic      m2_sel;
    logic      m3_sel;
    reg_addr_t ra_addr;
    reg_addr_t rc_addr;
  } wb_ctrl_t;

  function automatic reg_addr_t rc_of(inst_fields_t f);
    return f.low[RC_MSB:RC_LSB];
  endfunction

  function automatic func_t func_of(inst_fields_t f);
    return f.low[FUNC_MSB:FUNC_LSB];
  endfunction

  function automatic logic is_load(opcode_t op);
    return (op >= 6'h08 && op <= 6'h0C) || (op >= 6'h28 && op <= 6'h2B);
  endfunction

  function automatic logic is_operate(opcode_t op);
    return op == OP_INTA || op == OP_INTL || op == 6'h12 || op == 6'h13 || op == 6'h1C;
  endfunction

  // CMOVxx functions all end in 4 or 6
  function automatic logic is_cmov(inst_fields_t f);
    func_t fn;
    fn = func_of(f);
    return f.opcode == OP_INTL && (fn[3:0] == 4'h4 || fn[3:0] == 4'h6);
  endfunction

endpackage

`default_nettype wire
